// File: fas_top.f
+incdir+hdl
hdl/fas_pkg.sv
hdl/fir_window_if.sv
hdl/fir_delay_line.sv
hdl/fir_mac.sv
hdl/stp_deserializer.sv
hdl/fas_top.sv
dv/fas_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the FIR front end simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module fas_tb -f fas_top.f

result=$(./obj_dir/Vfas_tb 2>&1 || true)
printf '%s\n' "$result"

if printf '%s\n' "$result" | grep -qx "test passed"; then
  exit 0
fi
exit 1

// File: dv/fas_tb.sv
// ----------------------------------------
// FIR and frame builder testbench, reference model and checks
// ----------------------------------------
`timescale 1ns/100ps
`include "fas_config.svh"

module fas_tb;
  import fas_pkg::*;

  localparam int CLK_HALF   = 50;                     // 100 ns clock period
  localparam int DRIVE_DLY  = 10;                     // Inputs move this long after the edge
  localparam int WARMUP     = `FAS_NUM_TAPS - 1;      // Samples before the first output
  localparam int MAX_CYCLES = 3 * (8 + 32 + 73 + 300 + 104 + 79 + 5 * 8);  // About 1900

  // Filter taps as defined for the design, entry 0 weights the newest sample
  localparam coeff_t COEFF [`FAS_NUM_TAPS] = '{
    `FAS_COEFF_00, `FAS_COEFF_01, `FAS_COEFF_02, `FAS_COEFF_03,
    `FAS_COEFF_04, `FAS_COEFF_05, `FAS_COEFF_06, `FAS_COEFF_07,
    `FAS_COEFF_08, `FAS_COEFF_09, `FAS_COEFF_10, `FAS_COEFF_11,
    `FAS_COEFF_12, `FAS_COEFF_13, `FAS_COEFF_14, `FAS_COEFF_15,
    `FAS_COEFF_16, `FAS_COEFF_17, `FAS_COEFF_18, `FAS_COEFF_19,
    `FAS_COEFF_20, `FAS_COEFF_21, `FAS_COEFF_22, `FAS_COEFF_23,
    `FAS_COEFF_24, `FAS_COEFF_25, `FAS_COEFF_26, `FAS_COEFF_27,
    `FAS_COEFF_28, `FAS_COEFF_29, `FAS_COEFF_30, `FAS_COEFF_31
  };

  logic    clk = 1'b0;
  logic    rst;
  logic    data_valid;
  sample_t data;
  logic    fir_valid;
  sample_t fir_d;
  logic    frame_valid;
  frame_t  frame_d;

  tap_window_t win_m;            // Model window, index 0 newest
  int          fill_m;           // Model count of samples since restart
  sample_t     exp_q [$];        // Expected filter outputs in order
  logic        p1_m;             // Model pipe, result started
  logic        p2_m;             // Model pipe, one edge later
  logic        exp_valid;        // Expected fir_valid
  sample_t     exp_d;            // Expected fir_d
  frame_t      work_m;           // Model frame under construction
  int          slot_m;           // Model next slot
  logic        exp_frame_valid;  // Expected frame_valid
  frame_t      exp_frame;        // Expected frame_d

  string       test_name = "reset";
  int          errors = 0;
  int          err_mark = 0;
  int          out_total = 0;     // Every fir_valid cycle seen so far
  int          frame_total = 0;   // Every frame_valid cycle seen so far
  int          out_mark = 0;
  int          frame_mark = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycles;
  logic [15:0] lfsr_state = 16'd23;

  fas_top uut (
    .clk         (clk),
    .rst         (rst),
    .data_valid  (data_valid),
    .data        (data),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (frame_valid),
    .frame_d     (frame_d)
  );

  always #CLK_HALF clk = ~clk;

  // Sign of the full dot product, then its bits 30 down to 16
  function automatic sample_t fir_rule(input tap_window_t w);
    logic signed [63:0] dot;
    dot = '0;
    for (int i = 0; i < `FAS_NUM_TAPS; i++) begin
      dot = dot + longint'(w[i]) * longint'(COEFF[i]);  // Exact, no rounding
    end
    return {dot < 0, dot[30:16]};
  endfunction

  // x^16 + x^14 + x^13 + x^11 + 1, new bit enters at the bottom
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per sample bit
  task automatic random_sample(output sample_t s);
    s = '0;
    for (int b = 0; b < `FAS_SAMPLE_W; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      s = {s[`FAS_SAMPLE_W-2:0], lfsr_state[0]};
    end
  endtask

  // Reference model, one step per rising edge
  always @(posedge clk or posedge rst) begin
    if (rst) begin
      win_m = '0;
      fill_m = 0;
      exp_q.delete();
      work_m = '0;
      slot_m = 0;
      p1_m            <= 1'b0;
      p2_m            <= 1'b0;
      exp_valid       <= 1'b0;
      exp_d           <= '0;
      exp_frame_valid <= 1'b0;
      exp_frame       <= '0;
    end else begin
      if (data_valid) begin
        for (int i = `FAS_NUM_TAPS - 1; i > 0; i--) begin
          win_m[i] = win_m[i-1];  // Age every tap by one
        end
        win_m[0] = data;
        if (fill_m < `FAS_NUM_TAPS) fill_m++;
        if (fill_m == `FAS_NUM_TAPS) exp_q.push_back(fir_rule(win_m));
      end else begin
        win_m = '0;  // Idle cycle restarts from an empty window
        fill_m = 0;
      end
      // Frames are built from the outputs the model has already released
      if (exp_valid) begin
        work_m[slot_m] = exp_d;
        if (slot_m == `FAS_FRAME_LEN - 1) begin
          exp_frame       <= work_m;
          exp_frame_valid <= 1'b1;
          slot_m = 0;
        end else begin
          exp_frame_valid <= 1'b0;
          slot_m++;
        end
      end else begin
        exp_frame_valid <= 1'b0;
        slot_m = 0;  // Partial frame is lost
      end
      p1_m      <= data_valid && (fill_m == `FAS_NUM_TAPS);
      p2_m      <= p1_m;
      exp_valid <= p2_m;  // Output two edges after the accepting edge
      if (p2_m) exp_d <= exp_q.pop_front();
    end
  end

  // Running totals of DUT strobes
  always @(posedge clk) begin
    if (!rst && fir_valid) out_total++;
    if (!rst && frame_valid) frame_total++;
  end

  fir_timing: assert property (@(posedge clk) disable iff (rst) fir_valid == exp_valid)
    else begin
      errors++;
      $display("Fail %s fir_valid expected %b actual %b", test_name,
               $sampled(exp_valid), $sampled(fir_valid));
    end

  fir_value: assert property (@(posedge clk) disable iff (rst) fir_valid |-> fir_d == exp_d)
    else begin
      errors++;
      $display("Fail %s fir_d expected %h actual %h", test_name,
               $sampled(exp_d), $sampled(fir_d));
    end

  frame_timing: assert property (@(posedge clk) disable iff (rst)
    frame_valid == exp_frame_valid)
    else begin
      errors++;
      $display("Fail %s frame_valid expected %b actual %b", test_name,
               $sampled(exp_frame_valid), $sampled(frame_valid));
    end

  frame_value: assert property (@(posedge clk) disable iff (rst)
    frame_valid |-> frame_d == exp_frame)
    else begin
      errors++;
      $display("Fail %s frame_d expected %h actual %h", test_name,
               $sampled(exp_frame), $sampled(frame_d));
    end

  // Holds the inputs for one edge, then moves just past it
  task automatic send(input logic v, input sample_t s);
    data_valid = v;
    data       = s;
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic feed_random(input int n);
    sample_t s;
    for (int k = 0; k < n; k++) begin
      random_sample(s);
      send(1'b1, s);
    end
  endtask

  task automatic feed_value(input int n, input sample_t v);
    for (int k = 0; k < n; k++) begin
      send(1'b1, v);
    end
  endtask

  // Idles until every expected output and frame has come out
  task automatic drain();
    send(1'b0, '0);
    while (p1_m || p2_m || exp_valid || exp_frame_valid || exp_q.size() != 0) begin
      send(1'b0, '0);
    end
    send(1'b0, '0);
  endtask

  task automatic start_test(input string name);
    test_name  = name;
    err_mark   = errors;
    out_mark   = out_total;
    frame_mark = frame_total;
  endtask

  task automatic finish_test(input int exp_out, input int exp_frames);
    int n_out;
    int n_frames;
    drain();
    n_out    = out_total - out_mark;
    n_frames = frame_total - frame_mark;
    out_count: assert (n_out == exp_out) else begin
      errors++;
      $display("Fail %s output count expected %0d actual %0d", test_name, exp_out, n_out);
    end
    frame_count: assert (n_frames == exp_frames) else begin
      errors++;
      $display("Fail %s frame count expected %0d actual %0d", test_name, exp_frames, n_frames);
    end
    tests_run++;
    if (errors != err_mark) tests_failed++;
    $display("%s done, %0d outputs, %0d frames, %0d errors", test_name, n_out, n_frames,
             errors - err_mark);
  endtask

  initial begin
    rst        = 1'b1;
    data_valid = 1'b0;
    data       = '0;
    repeat (8) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;

    start_test("reset_quiet");
    feed_random(`FAS_NUM_TAPS);  // Only the 32nd sample yields an output
    finish_test(1, 0);

    start_test("impulse");
    feed_value(`FAS_NUM_TAPS, '0);  // Fill the window with zeros first
    send(1'b1, 16'sd16384);
    feed_value(40, '0);
    finish_test(`FAS_NUM_TAPS + 41 - WARMUP, 2);

    start_test("random_stream");
    feed_random(300);
    finish_test(300 - WARMUP, (300 - WARMUP) / `FAS_FRAME_LEN);

    start_test("restart");
    feed_random(40);
    send(1'b0, '0);  // Single idle cycle mid-stream
    feed_random(WARMUP + 2 * `FAS_FRAME_LEN);
    finish_test(40 - WARMUP + 2 * `FAS_FRAME_LEN, 2);

    start_test("frames");
    feed_random(WARMUP + 3 * `FAS_FRAME_LEN);
    finish_test(3 * `FAS_FRAME_LEN, 3);

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Run limit, well above the summed stream and drain lengths
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles in %s, the outputs never went idle", cycles, test_name);
    $display("test failed");
    $finish;
  end

endmodule

// File: hdl/fas_top.sv
// ----------------------------------------
// Frequency analysis front end top level
// ----------------------------------------
`timescale 1ns/100ps

module fas_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             data_valid,
  input  fas_pkg::sample_t data,
  output logic             fir_valid,
  output fas_pkg::sample_t fir_d,
  output logic             frame_valid,
  output fas_pkg::frame_t  frame_d
);

  fir_window_if win ();  // Tap window from the delay line to the MAC

  // Sample window and fill tracking
  fir_delay_line u_delay_line (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .win        (win.producer)
  );

  // Dot product, two cycles after each full window
  fir_mac u_mac (
    .clk       (clk),
    .rst       (rst),
    .win       (win.consumer),
    .fir_valid (fir_valid),
    .fir_d     (fir_d)
  );

  // Filter output also feeds the frame builder
  stp_deserializer u_stp (
    .clk         (clk),
    .rst         (rst),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (frame_valid),
    .frame_d     (frame_d)
  );

endmodule

// File: hdl/stp_deserializer.sv
// ----------------------------------------
// Serial to parallel frame builder
// ----------------------------------------
`timescale 1ns/100ps
`include "fas_config.svh"

module stp_deserializer (
  input  logic             clk,
  input  logic             rst,
  input  logic             fir_valid,
  input  fas_pkg::sample_t fir_d,
  output logic             frame_valid,
  output fas_pkg::frame_t  frame_d
);
  import fas_pkg::*;

  localparam int IDX_W = $clog2(`FAS_FRAME_LEN);

  logic [IDX_W-1:0] slot_q;      // Next slot to fill
  frame_t           work_q;      // Frame under construction
  frame_t           work_next;   // Working frame with this cycle's sample placed
  logic             last;        // This sample completes a frame

  assign last = fir_valid && (slot_q == IDX_W'(`FAS_FRAME_LEN - 1));

  // Drop the incoming sample into its slot
  always_comb begin
    work_next         = work_q;
    work_next[slot_q] = fir_d;
  end

  // Payload, stale slots of a dropped frame get overwritten before use
  always_ff @(posedge clk) begin
    if (fir_valid) begin
      work_q <= work_next;
    end
    if (last) begin
      frame_d <= work_next;  // Holds until the next complete frame
    end
  end

  // Slot index and frame strobe
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      slot_q      <= '0;
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= last;
      if (!fir_valid || last) begin
        slot_q <= '0;          // A gap discards the partial frame
      end else begin
        slot_q <= slot_q + 1'b1;
      end
    end
  end

  // Sixteen samples separate any two frames
  frame_pulse_single: assert property (
    @(posedge clk) disable iff (rst)
    frame_valid |=> !frame_valid
  );

endmodule

// File: hdl/fir_mac.sv
// ----------------------------------------
// Two-stage FIR multiply-accumulate
// ----------------------------------------
`timescale 1ns/100ps
`include "fas_config.svh"

module fir_mac (
  input  logic             clk,
  input  logic             rst,
  fir_window_if.consumer   win,
  output logic             fir_valid,
  output fas_pkg::sample_t fir_d
);
  import fas_pkg::*;

  localparam int NUM_GRP = 4;                          // Partial sums in stage one
  localparam int GRP_LEN = `FAS_NUM_TAPS / NUM_GRP;    // Eight products per group
  localparam int PROD_W  = `FAS_SAMPLE_W + `FAS_COEFF_W;
  localparam int MSB_OUT = `FAS_FRAC_BITS + `FAS_SAMPLE_W - 2;  // Top magnitude bit kept

  // Coefficient table, entry i weights the i-th newest sample
  localparam coeff_t COEFF [`FAS_NUM_TAPS] = '{
    `FAS_COEFF_00, `FAS_COEFF_01, `FAS_COEFF_02, `FAS_COEFF_03,
    `FAS_COEFF_04, `FAS_COEFF_05, `FAS_COEFF_06, `FAS_COEFF_07,
    `FAS_COEFF_08, `FAS_COEFF_09, `FAS_COEFF_10, `FAS_COEFF_11,
    `FAS_COEFF_12, `FAS_COEFF_13, `FAS_COEFF_14, `FAS_COEFF_15,
    `FAS_COEFF_16, `FAS_COEFF_17, `FAS_COEFF_18, `FAS_COEFF_19,
    `FAS_COEFF_20, `FAS_COEFF_21, `FAS_COEFF_22, `FAS_COEFF_23,
    `FAS_COEFF_24, `FAS_COEFF_25, `FAS_COEFF_26, `FAS_COEFF_27,
    `FAS_COEFF_28, `FAS_COEFF_29, `FAS_COEFF_30, `FAS_COEFF_31
  };

  logic signed [PROD_W-1:0] prod [`FAS_NUM_TAPS];  // Full-precision tap products
  acc_t                     grp_sum [NUM_GRP];     // Stage one adder trees
  acc_t                     grp_q [NUM_GRP];       // Stage one registers
  acc_t                     dot_sum;               // Final adder in stage two
  logic                     start;                 // New full window to process
  logic                     v1_q;                  // Stage one holds a live result

  // A result starts only on a fresh sample into a full window
  assign start = win.take && win.full && !win.clear;

  // Products and the four eight-input partial sums
  always_comb begin
    for (int i = 0; i < `FAS_NUM_TAPS; i++) begin
      prod[i] = win.taps[i] * COEFF[i];  // Signed 16 x 16, exact in 32 bits
    end
    for (int g = 0; g < NUM_GRP; g++) begin
      grp_sum[g] = '0;
      for (int j = 0; j < GRP_LEN; j++) begin
        grp_sum[g] = grp_sum[g] + prod[g*GRP_LEN + j];  // Sign-extends to 40 bits
      end
    end
  end

  // Stage one payload, held while idle
  always_ff @(posedge clk) begin
    if (start) begin
      grp_q <= grp_sum;
    end
  end

  assign dot_sum = grp_q[0] + grp_q[1] + grp_q[2] + grp_q[3];

  // Stage two payload, sign then bits 30 down to 16 of the dot product
  always_ff @(posedge clk) begin
    if (v1_q) begin
      fir_d <= {dot_sum[`FAS_ACC_W-1], dot_sum[MSB_OUT:`FAS_FRAC_BITS]};
    end
  end

  // Valid pipe, in-flight results drain even across a restart
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      v1_q      <= 1'b0;
      fir_valid <= 1'b0;
    end else begin
      v1_q      <= start;
      fir_valid <= v1_q;
    end
  end

  // Every output traces back to a gated take two edges earlier
  valid_from_start: assert property (
    @(posedge clk) disable iff (rst)
    fir_valid |-> $past(start, 2)
  );

endmodule

// File: hdl/fir_delay_line.sv
// ----------------------------------------
// FIR tap delay line and fill counter
// ----------------------------------------
`timescale 1ns/100ps
`include "fas_config.svh"

module fir_delay_line (
  input  logic             clk,
  input  logic             rst,
  input  logic             data_valid,
  input  fas_pkg::sample_t data,
  fir_window_if.producer   win
);
  import fas_pkg::*;

  localparam int CNT_W = $clog2(`FAS_NUM_TAPS + 1);  // Must reach 32, not wrap at it

  tap_window_t      taps_q;   // Shift register, newest at index 0
  logic [CNT_W-1:0] cnt_q;    // Samples accepted since restart, saturates
  logic             take_q;   // Marks the cycle after an accepted sample
  logic             clear_q;  // Marks the cycle after a restart

  // Window contents, zeroed by any gap in the input strobe
  always_ff @(posedge clk) begin
    if (data_valid) begin
      taps_q <= {taps_q[`FAS_NUM_TAPS-2:0], data};  // Oldest sample drops off the top
    end else begin
      taps_q <= '0;  // Restart from an empty window
    end
  end

  // Fill count and the two strobes
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt_q   <= '0;
      take_q  <= 1'b0;
      clear_q <= 1'b0;
    end else begin
      take_q  <= data_valid;                          // One pulse per accepted sample
      clear_q <= !data_valid && (cnt_q != '0);        // Pulse once, on the gap that empties it
      if (!data_valid) begin
        cnt_q <= '0;                                  // Gap restarts the fill
      end else if (cnt_q != CNT_W'(`FAS_NUM_TAPS)) begin
        cnt_q <= cnt_q + 1'b1;                        // Counts up, then holds at 32
      end
    end
  end

  assign win.taps  = taps_q;
  assign win.take  = take_q;
  assign win.full  = (cnt_q == CNT_W'(`FAS_NUM_TAPS));  // Decoded from the registered count
  assign win.clear = clear_q;

  // The window can only become full on the edge that shifts a sample in
  full_needs_take: assert property (
    @(posedge clk) disable iff (rst)
    $rose(win.full) |-> win.take
  );

endmodule

// File: hdl/fir_window_if.sv
// ----------------------------------------
// Tap window bus, delay line to MAC
// ----------------------------------------
`timescale 1ns/100ps

interface fir_window_if;
  import fas_pkg::*;

  tap_window_t taps;   // Current window, index 0 newest
  logic        take;   // Window shifted in a new sample last edge
  logic        full;   // All 32 taps hold samples since the last restart
  logic        clear;  // Window was just emptied by an idle cycle

  // The delay line owns every signal
  modport producer (
    output taps,
    output take,
    output full,
    output clear
  );

  // No back-pressure, the MAC only listens
  modport consumer (
    input taps,
    input take,
    input full,
    input clear
  );

endinterface

// File: hdl/fas_pkg.sv
// ----------------------------------------
// Shared sample, window and frame types
// ----------------------------------------
`include "fas_config.svh"

package fas_pkg;

  // One input or filtered sample
  typedef logic signed [`FAS_SAMPLE_W-1:0] sample_t;

  // One filter coefficient, pure fraction
  typedef logic signed [`FAS_COEFF_W-1:0] coeff_t;

  // Running dot product of the whole window
  typedef logic signed [`FAS_ACC_W-1:0] acc_t;

  // Full tap window, element 0 is the newest sample
  // Elements keep the signed sample_t type when selected
  typedef sample_t [`FAS_NUM_TAPS-1:0] tap_window_t;

  // One frame for the transform stage, slot 0 is the oldest output
  typedef sample_t [`FAS_FRAME_LEN-1:0] frame_t;

endpackage

// File: hdl/fas_config.svh
// ----------------------------------------
// Widths, sizes and FIR coefficients
// ----------------------------------------
`ifndef FAS_CONFIG_SVH
`define FAS_CONFIG_SVH

`define FAS_SAMPLE_W  16  // Input and filtered sample width
`define FAS_COEFF_W   16  // Coefficient word, all 16 bits are fraction
`define FAS_NUM_TAPS  32  // Filter length
`define FAS_ACC_W     40  // Holds the sum of 32 full products with headroom
`define FAS_FRAC_BITS 16  // Binary point position of each product
`define FAS_FRAME_LEN 16  // Filter outputs gathered per frame

// Low-pass taps, symmetric about the middle of the window
// Tap 00 weights the newest sample and tap 31 the oldest
`define FAS_COEFF_00 16'shFFC0  // -64
`define FAS_COEFF_01 16'shFF90  // -112
`define FAS_COEFF_02 16'shFF58  // -168
`define FAS_COEFF_03 16'shFF28  // -216
`define FAS_COEFF_04 16'shFF18  // -232
`define FAS_COEFF_05 16'shFF48  // -184
`define FAS_COEFF_06 16'shFFD8  // -40
`define FAS_COEFF_07 16'sh00E0  // 224
`define FAS_COEFF_08 16'sh0270  // 624
`define FAS_COEFF_09 16'sh0480  // 1152
`define FAS_COEFF_10 16'sh06F0  // 1776
`define FAS_COEFF_11 16'sh0990  // 2448
`define FAS_COEFF_12 16'sh0C20  // 3104
`define FAS_COEFF_13 16'sh0E58  // 3672
`define FAS_COEFF_14 16'sh0FF8  // 4088
`define FAS_COEFF_15 16'sh10D0  // 4304, peak of the first half

// Second half mirrors the first
`define FAS_COEFF_16 16'sh10D0
`define FAS_COEFF_17 16'sh0FF8
`define FAS_COEFF_18 16'sh0E58
`define FAS_COEFF_19 16'sh0C20
`define FAS_COEFF_20 16'sh0990
`define FAS_COEFF_21 16'sh06F0
`define FAS_COEFF_22 16'sh0480
`define FAS_COEFF_23 16'sh0270
`define FAS_COEFF_24 16'sh00E0
`define FAS_COEFF_25 16'shFFD8
`define FAS_COEFF_26 16'shFF48
`define FAS_COEFF_27 16'shFF18
`define FAS_COEFF_28 16'shFF28
`define FAS_COEFF_29 16'shFF58
`define FAS_COEFF_30 16'shFF90
`define FAS_COEFF_31 16'shFFC0

// DC gain of the set is about 0.62, so a full-scale input
// settles well inside the 16-bit output range

`endif
